// ==== mem_xlate_defs.svh ====
`ifndef MEM_XLATE_DEFS_SVH
`define MEM_XLATE_DEFS_SVH

// tlb geometry
`define TLBNUM      16
`define TLB_IDX_W   4

// address widths
`define VA_W        32
`define PA_W        32

// page size codes, log2 of page bytes
`define PS_4K       12
`define PS_2M       21

// exception codes
`define ECODE_ALE   6'h09
`define ECODE_TLBR  6'h3F
`define ECODE_PIL   6'h01
`define ECODE_PPI   6'h07

`endif

// ==== src/xlate_pkg.sv ====
`include "mem_xlate_defs.svh"

package xlate_pkg;

    // even or odd half of a tlb entry
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic        g;
        logic [9:0]  asid;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    // one direct mapped window
    typedef struct packed {
        logic       plv_met;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_cfg_t;

    typedef struct packed {
        logic       pg;
        logic [1:0] plv;
        logic [9:0] asid;
        dmw_cfg_t   dmw0;
        dmw_cfg_t   dmw1;
    } xlate_cfg_t;

    // search answer, page already picked by the odd/even bit
    typedef struct packed {
        logic                  found;
        logic [`TLB_IDX_W-1:0] index;
        logic [5:0]            ps;
        tlb_page_t             page;
    } tlb_result_t;

endpackage

// ==== src/pipe_pkg.sv ====
`include "mem_xlate_defs.svh"

package pipe_pkg;

    // load as it enters the translate stage
    typedef struct packed {
        logic [`VA_W-1:0] va;
    } load_req_t;

    // translate to memory payload
    typedef struct packed {
        logic [`PA_W-1:0] pa;
        logic             exc;
        logic [5:0]       ecode;
    } xlated_t;

    // what the memory stage hands out
    typedef struct packed {
        logic [`PA_W-1:0] pa;
        logic [31:0]      data;
        logic             exc;
        logic [5:0]       ecode;
    } load_result_t;

endpackage

// ==== src/tlb.sv ====
`timescale 1ns/1ps
`include "mem_xlate_defs.svh"

module tlb (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   we,
    input  logic [`TLB_IDX_W-1:0]  windex,
    input  xlate_pkg::tlb_entry_t  wentry,
    input  logic [`VA_W-1:0]       s_va,
    input  logic [9:0]             s_asid,
    output xlate_pkg::tlb_result_t s_result
);

    xlate_pkg::tlb_entry_t entry_q [`TLBNUM];
    logic [`TLBNUM-1:0]    e_q;
    logic [`TLBNUM-1:0]    match;
    logic [`TLB_IDX_W-1:0] hit_idx;
    xlate_pkg::tlb_entry_t hit_entry;
    logic                  odd_sel;

    // valid bits are the only state that needs clearing
    always_ff @(posedge aclk) begin
        if (rst) begin
            e_q <= '0;
        end else if (we) begin
            e_q[windex] <= wentry.e;
        end
    end

    always_ff @(posedge aclk) begin
        if (we) begin
            entry_q[windex] <= wentry;
        end
    end

    // parallel compare, 2M pages only look at the top 10 vppn bits
    for (genvar i = 0; i < `TLBNUM; i++) begin : g_match
        logic is_2m;
        logic vppn_hit;
        logic asid_hit;

        assign is_2m    = entry_q[i].ps == 6'(`PS_2M);
        assign vppn_hit = is_2m ? (entry_q[i].vppn[18:9] == s_va[31:22])
                                : (entry_q[i].vppn == s_va[31:13]);
        assign asid_hit = entry_q[i].g || (entry_q[i].asid == s_asid);
        assign match[i] = e_q[i] && asid_hit && vppn_hit;
    end

    // lowest matching index wins
    always_comb begin
        hit_idx = '0;
        for (int i = `TLBNUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = i[`TLB_IDX_W-1:0];
            end
        end
    end

    assign hit_entry = entry_q[hit_idx];

    // odd page bit sits just above the page offset
    assign odd_sel = (hit_entry.ps == 6'(`PS_2M)) ? s_va[21] : s_va[12];

    always_comb begin
        s_result.found = |match;
        s_result.index = hit_idx;
        s_result.ps    = hit_entry.ps;
        s_result.page  = odd_sel ? hit_entry.page1 : hit_entry.page0;
    end

endmodule

// ==== src/addr_xlate_stage.sv ====
`timescale 1ns/1ps
`include "mem_xlate_defs.svh"

module addr_xlate_stage (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  pipe_pkg::load_req_t    req,
    input  xlate_pkg::xlate_cfg_t  cfg,
    input  xlate_pkg::tlb_result_t tlb_result,
    input  logic                   mem_allowin,
    output logic                   req_ready,
    output logic [`VA_W-1:0]       tlb_va,
    output logic                   xlate_valid,
    output pipe_pkg::xlated_t      xlated
);

    logic              start_q;
    logic              valid_q;
    pipe_pkg::xlated_t xlated_q;
    pipe_pkg::xlated_t xlated_d;
    logic              dmw0_hit;
    logic              dmw1_hit;
    logic              tlb_2m;
    logic [`PA_W-1:0]  tlb_pa;

    // search runs on the incoming address, result used in the same cycle
    assign tlb_va = req.va;

    assign dmw0_hit = cfg.dmw0.plv_met && (req.va[31:29] == cfg.dmw0.vseg);
    assign dmw1_hit = cfg.dmw1.plv_met && (req.va[31:29] == cfg.dmw1.vseg);

    assign tlb_2m = tlb_result.ps == 6'(`PS_2M);
    assign tlb_pa = tlb_2m ? {tlb_result.page.ppn[19:9], req.va[20:0]}
                           : {tlb_result.page.ppn, req.va[11:0]};

    // priority order: alignment, direct mode, dmw0, dmw1, tlb
    always_comb begin
        xlated_d.pa    = req.va;
        xlated_d.exc   = 1'b0;
        xlated_d.ecode = 6'd0;
        if (req.va[1:0] != 2'b00) begin
            xlated_d.exc   = 1'b1;
            xlated_d.ecode = `ECODE_ALE;
        end else if (!cfg.pg) begin
            xlated_d.pa = req.va;
        end else if (dmw0_hit) begin
            xlated_d.pa = {cfg.dmw0.pseg, req.va[28:0]};
        end else if (dmw1_hit) begin
            xlated_d.pa = {cfg.dmw1.pseg, req.va[28:0]};
        end else if (!tlb_result.found) begin
            xlated_d.exc   = 1'b1;
            xlated_d.ecode = `ECODE_TLBR;
        end else if (!tlb_result.page.v) begin
            xlated_d.exc   = 1'b1;
            xlated_d.ecode = `ECODE_PIL;
        end else if (cfg.plv > tlb_result.page.plv) begin
            xlated_d.exc   = 1'b1;
            xlated_d.ecode = `ECODE_PPI;
        end else begin
            xlated_d.pa = tlb_pa;
        end
    end

    // first cycle out of reset stays closed
    assign req_ready   = start_q && (!valid_q || mem_allowin);
    assign xlate_valid = valid_q;
    assign xlated      = xlated_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            start_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            start_q <= 1'b1;
            if (req_ready) begin
                valid_q <= req_valid;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid && req_ready) begin
            xlated_q <= xlated_d;
        end
    end

endmodule

// ==== src/mem_access_stage.sv ====
`timescale 1ns/1ps
`include "mem_xlate_defs.svh"

module mem_access_stage (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   xlate_valid,
    input  pipe_pkg::xlated_t      xlated,
    output logic                   mem_allowin,
    output logic                   data_req,
    output logic [`PA_W-1:0]       data_addr,
    input  logic                   data_addr_ok,
    input  logic                   data_data_ok,
    input  logic [31:0]            data_rdata,
    output logic                   result_valid,
    output pipe_pkg::load_result_t result,
    input  logic                   result_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } state_t;

    state_t                 state_q;
    pipe_pkg::xlated_t      item_q;
    logic                   res_valid_q;
    pipe_pkg::load_result_t res_q;
    logic                   res_free;
    logic                   take;
    logic                   take_exc;
    logic                   rdata_done;

    assign res_free    = !res_valid_q || result_ready;
    assign mem_allowin = (state_q == st_idle) && res_free;
    assign take        = xlate_valid && mem_allowin;
    assign take_exc    = take && xlated.exc;
    assign rdata_done  = (state_q == st_wait) && data_data_ok;

    // one read outstanding at most
    assign data_req  = state_q == st_req;
    assign data_addr = item_q.pa;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    // faulting loads skip the bus
                    if (take && !xlated.exc) begin
                        state_q <= st_req;
                    end
                end
                st_req: begin
                    if (data_addr_ok) begin
                        state_q <= st_wait;
                    end
                end
                st_wait: begin
                    if (data_data_ok) begin
                        state_q <= st_idle;
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            item_q <= xlated;
        end
    end

    // result slot is known free whenever it gets loaded
    always_ff @(posedge aclk) begin
        if (rst) begin
            res_valid_q <= 1'b0;
        end else if (take_exc || rdata_done) begin
            res_valid_q <= 1'b1;
        end else if (result_ready) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (take_exc) begin
            res_q.pa    <= xlated.pa;
            res_q.data  <= 32'd0;
            res_q.exc   <= 1'b1;
            res_q.ecode <= xlated.ecode;
        end else if (rdata_done) begin
            res_q.pa    <= item_q.pa;
            res_q.data  <= data_rdata;
            res_q.exc   <= item_q.exc;
            res_q.ecode <= item_q.ecode;
        end
    end

    assign result_valid = res_valid_q;
    assign result       = res_q;

endmodule

// ==== src/mem_xlate_top.sv ====
`timescale 1ns/1ps
`include "mem_xlate_defs.svh"

module mem_xlate_top (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  pipe_pkg::load_req_t    req,
    input  xlate_pkg::xlate_cfg_t  cfg,
    input  logic                   tlb_we,
    input  logic [`TLB_IDX_W-1:0]  tlb_windex,
    input  xlate_pkg::tlb_entry_t  tlb_wentry,
    output logic                   data_req,
    output logic [`PA_W-1:0]       data_addr,
    input  logic                   data_addr_ok,
    input  logic                   data_data_ok,
    input  logic [31:0]            data_rdata,
    output logic                   result_valid,
    input  logic                   result_ready,
    output pipe_pkg::load_result_t result
);

    logic [`VA_W-1:0]       tlb_va;
    xlate_pkg::tlb_result_t tlb_result;
    logic                   xlate_valid;
    pipe_pkg::xlated_t      xlated;
    logic                   mem_allowin;

    tlb u_tlb (
        .aclk         (aclk),
        .rst          (rst),
        .we           (tlb_we),
        .windex       (tlb_windex),
        .wentry       (tlb_wentry),
        .s_va         (tlb_va),
        .s_asid       (cfg.asid),
        .s_result     (tlb_result)
    );

    addr_xlate_stage u_xlate (
        .aclk         (aclk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .cfg          (cfg),
        .tlb_result   (tlb_result),
        .mem_allowin  (mem_allowin),
        .req_ready    (req_ready),
        .tlb_va       (tlb_va),
        .xlate_valid  (xlate_valid),
        .xlated       (xlated)
    );

    mem_access_stage u_mem (
        .aclk         (aclk),
        .rst          (rst),
        .xlate_valid  (xlate_valid),
        .xlated       (xlated),
        .mem_allowin  (mem_allowin),
        .data_req     (data_req),
        .data_addr    (data_addr),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

endmodule

// ==== testbench/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
    input  logic        aclk,
    input  logic        rst,
    input  logic        data_req,
    input  logic [31:0] data_addr,
    output logic        data_addr_ok,
    output logic        data_data_ok,
    output logic [31:0] data_rdata,
    output logic [31:0] req_count
);

    logic        addr_armed;
    logic [1:0]  addr_wait;
    logic        data_pend;
    logic [1:0]  data_wait;
    logic [31:0] addr_q;

    // read data is the inverse of the address, each phase waits 0 to 3 cycles
    always @(posedge aclk) begin : respond
        int unsigned delay;
        delay = $urandom % 4;
        if (rst) begin
            data_addr_ok <= 1'b0;
            data_data_ok <= 1'b0;
            data_rdata   <= '0;
            req_count    <= '0;
            addr_armed   <= 1'b0;
            addr_wait    <= '0;
            data_pend    <= 1'b0;
            data_wait    <= '0;
            addr_q       <= '0;
        end else begin
            data_data_ok <= 1'b0;
            if (data_addr_ok) begin
                // address accepted on this edge
                data_addr_ok <= 1'b0;
                addr_armed   <= 1'b0;
                req_count    <= req_count + 32'd1;
                addr_q       <= data_addr;
                if (delay == 0) begin
                    data_data_ok <= 1'b1;
                    data_rdata   <= ~data_addr;
                end else begin
                    data_pend <= 1'b1;
                    data_wait <= 2'(delay - 1);
                end
            end else if (data_pend) begin
                if (data_wait == 2'd0) begin
                    data_data_ok <= 1'b1;
                    data_rdata   <= ~addr_q;
                    data_pend    <= 1'b0;
                end else begin
                    data_wait <= data_wait - 2'd1;
                end
            end else if (data_req) begin
                if (!addr_armed) begin
                    if (delay == 0) begin
                        data_addr_ok <= 1'b1;
                    end else begin
                        addr_armed <= 1'b1;
                        addr_wait  <= 2'(delay - 1);
                    end
                end else if (addr_wait == 2'd0) begin
                    data_addr_ok <= 1'b1;
                    addr_armed   <= 1'b0;
                end else begin
                    addr_wait <= addr_wait - 2'd1;
                end
            end
        end
    end

endmodule

// ==== testbench/tb_mem_xlate.sv ====
`timescale 1ns/1ps
`include "mem_xlate_defs.svh"

module tb_mem_xlate;

    localparam int TIMEOUT = 200;

    // one load: config, address and what should come back
    typedef struct packed {
        xlate_pkg::xlate_cfg_t cfg;
        logic [31:0]           va;
        logic                  exc;
        logic [5:0]            ecode;
        logic [31:0]           pa;
    } load_row_t;

    logic                   aclk;
    logic                   rst;
    logic                   req_valid;
    logic                   req_ready;
    pipe_pkg::load_req_t    req;
    xlate_pkg::xlate_cfg_t  cfg;
    logic                   tlb_we;
    logic [`TLB_IDX_W-1:0]  tlb_windex;
    xlate_pkg::tlb_entry_t  tlb_wentry;
    logic                   data_req;
    logic [31:0]            data_addr;
    logic                   data_addr_ok;
    logic                   data_data_ok;
    logic [31:0]            data_rdata;
    logic                   result_valid;
    logic                   result_ready;
    pipe_pkg::load_result_t result;
    logic [31:0]            req_count;

    load_row_t               rows[$];
    xlate_pkg::tlb_entry_t   tlb_tab[$];
    logic [`TLB_IDX_W-1:0]   tlb_idx[$];

    always #5 aclk = ~aclk;

    mem_xlate_top uut (
        .aclk         (aclk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .cfg          (cfg),
        .tlb_we       (tlb_we),
        .tlb_windex   (tlb_windex),
        .tlb_wentry   (tlb_wentry),
        .data_req     (data_req),
        .data_addr    (data_addr),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    tb_mem_model u_mem_model (
        .aclk         (aclk),
        .rst          (rst),
        .data_req     (data_req),
        .data_addr    (data_addr),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .data_rdata   (data_rdata),
        .req_count    (req_count)
    );

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_load(input int row, input pipe_pkg::load_result_t got,
                              input pipe_pkg::load_result_t exp);
        if (got.pa !== exp.pa || got.data !== exp.data) begin
            $display("Error at time %0t: row %0d pa %h data %h, expected pa %h data %h",
                     $time, row, got.pa, got.data, exp.pa, exp.data);
            stop_run();
        end
    endtask

    task automatic check_exc(input int row, input pipe_pkg::load_result_t got,
                             input pipe_pkg::load_result_t exp);
        if (got.exc !== exp.exc || got.ecode !== exp.ecode) begin
            $display("Error at time %0t: row %0d exc %b ecode %h, expected exc %b ecode %h",
                     $time, row, got.exc, got.ecode, exp.exc, exp.ecode);
            stop_run();
        end
    endtask

    task automatic check_count(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at time %0t: memory saw %0d reads, expected %0d",
                     $time, got, exp);
            stop_run();
        end
    endtask

    function automatic xlate_pkg::xlate_cfg_t make_cfg(
        input logic pg, input logic [1:0] plv, input logic [9:0] asid,
        input logic m0, input logic [2:0] vs0, input logic [2:0] ps0,
        input logic m1, input logic [2:0] vs1, input logic [2:0] ps1);
        xlate_pkg::xlate_cfg_t c;
        c.pg           = pg;
        c.plv          = plv;
        c.asid         = asid;
        c.dmw0.plv_met = m0;
        c.dmw0.vseg    = vs0;
        c.dmw0.pseg    = ps0;
        c.dmw1.plv_met = m1;
        c.dmw1.vseg    = vs1;
        c.dmw1.pseg    = ps1;
        return c;
    endfunction

    function automatic xlate_pkg::tlb_entry_t make_entry(
        input logic [18:0] vppn, input logic [5:0] ps, input logic g, input logic [9:0] asid,
        input logic [19:0] ppn0, input logic [1:0] plv0, input logic v0,
        input logic [19:0] ppn1, input logic [1:0] plv1, input logic v1);
        xlate_pkg::tlb_entry_t t;
        t       = '0;
        t.e     = 1'b1;
        t.vppn  = vppn;
        t.ps    = ps;
        t.g     = g;
        t.asid  = asid;
        t.page0 = '{ppn: ppn0, plv: plv0, mat: 2'b01, d: 1'b0, v: v0};
        t.page1 = '{ppn: ppn1, plv: plv1, mat: 2'b01, d: 1'b0, v: v1};
        return t;
    endfunction

    task automatic add_ok(input xlate_pkg::xlate_cfg_t c, input logic [31:0] va,
                          input logic [31:0] pa);
        rows.push_back('{cfg: c, va: va, exc: 1'b0, ecode: 6'd0, pa: pa});
    endtask

    // faulting loads report pa equal to va
    task automatic add_exc(input xlate_pkg::xlate_cfg_t c, input logic [31:0] va,
                           input logic [5:0] ecode);
        rows.push_back('{cfg: c, va: va, exc: 1'b1, ecode: ecode, pa: va});
    endtask

    task automatic add_tlb(input logic [`TLB_IDX_W-1:0] idx, input xlate_pkg::tlb_entry_t t);
        tlb_idx.push_back(idx);
        tlb_tab.push_back(t);
    endtask

    task automatic build_tables();
        xlate_pkg::xlate_cfg_t cfg_da;
        xlate_pkg::xlate_cfg_t cfg_pg;
        xlate_pkg::xlate_cfg_t cfg_both;
        xlate_pkg::xlate_cfg_t cfg_nomet;
        xlate_pkg::xlate_cfg_t cfg_asid2;
        xlate_pkg::xlate_cfg_t cfg_plv3;
        xlate_pkg::tlb_entry_t dis;
        cfg_da    = make_cfg(0, 2'd0, 10'h000, 0, 3'd0, 3'd0, 0, 3'd0, 3'd0);
        cfg_pg    = make_cfg(1, 2'd0, 10'h011, 1, 3'd4, 3'd1, 1, 3'd5, 3'd2);
        cfg_both  = make_cfg(1, 2'd0, 10'h011, 1, 3'd6, 3'd3, 1, 3'd6, 3'd5);
        cfg_nomet = make_cfg(1, 2'd0, 10'h011, 0, 3'd4, 3'd1, 0, 3'd5, 3'd2);
        cfg_asid2 = make_cfg(1, 2'd0, 10'h022, 0, 3'd4, 3'd1, 0, 3'd5, 3'd2);
        cfg_plv3  = make_cfg(1, 2'd3, 10'h011, 0, 3'd4, 3'd1, 0, 3'd5, 3'd2);

        add_tlb(4'd0, make_entry(19'h12345, 6'(`PS_4K), 0, 10'h011,
                                 20'h0AAAA, 2'd3, 1, 20'h0BBBB, 2'd0, 1));
        add_tlb(4'd5, make_entry(19'h20200, 6'(`PS_2M), 1, 10'h3FF,
                                 20'h12200, 2'd0, 1, 20'h34600, 2'd0, 1));
        add_tlb(4'd9, make_entry(19'h40008, 6'(`PS_4K), 0, 10'h011,
                                 20'h00777, 2'd0, 1, 20'h00888, 2'd0, 0));
        dis   = make_entry(19'h30000, 6'(`PS_4K), 1, 10'h000,
                           20'h00123, 2'd0, 1, 20'h00124, 2'd0, 1);
        dis.e = 1'b0;
        add_tlb(4'd3, dis);

        add_ok(cfg_da, 32'h2468A010, 32'h2468A010);
        add_ok(cfg_da, 32'hDEADBEE0, 32'hDEADBEE0);
        add_exc(cfg_da, 32'h00001002, `ECODE_ALE);
        add_ok(cfg_pg, 32'h80010020, 32'h20010020);
        add_ok(cfg_pg, 32'hA0000104, 32'h40000104);
        add_ok(cfg_both, 32'hC0000200, 32'h60000200);
        add_ok(cfg_nomet, 32'h80010020, 32'h00777020);
        add_exc(cfg_nomet, 32'h80011000, `ECODE_PIL);
        add_ok(cfg_pg, 32'h2468A010, 32'h0AAAA010);
        add_ok(cfg_pg, 32'h2468B01C, 32'h0BBBB01C);
        add_exc(cfg_plv3, 32'h2468B01C, `ECODE_PPI);
        add_ok(cfg_plv3, 32'h2468A010, 32'h0AAAA010);
        add_ok(cfg_pg, 32'h40412344, 32'h12212344);
        add_ok(cfg_asid2, 32'h40612348, 32'h34612348);
        add_exc(cfg_asid2, 32'h2468A010, `ECODE_TLBR);
        add_exc(cfg_pg, 32'h60000000, `ECODE_TLBR);
        add_exc(cfg_pg, 32'h40412346, `ECODE_ALE);
        add_ok(cfg_da, 32'h00000FFC, 32'h00000FFC);
    endtask

    task automatic fill_tlb();
        for (int k = 0; k < tlb_tab.size(); k++) begin
            tlb_we     <= 1'b1;
            tlb_windex <= tlb_idx[k];
            tlb_wentry <= tlb_tab[k];
            @(posedge aclk);
        end
        tlb_we <= 1'b0;
        @(posedge aclk);
    endtask

    task automatic send_loads();
        int waited;
        for (int i = 0; i < rows.size(); i++) begin
            req_valid <= 1'b1;
            req.va    <= rows[i].va;
            cfg       <= rows[i].cfg;
            waited = 0;
            @(negedge aclk);
            while (!req_ready) begin
                waited++;
                if (waited > TIMEOUT) begin
                    $display("Timeout waiting for req_ready on row %0d", i);
                    stop_run();
                end
                @(negedge aclk);
            end
            @(posedge aclk);
            // occasional idle cycle between requests
            if ($urandom % 4 == 0) begin
                req_valid <= 1'b0;
                @(posedge aclk);
            end
        end
        req_valid <= 1'b0;
    endtask

    task automatic collect_results();
        int                     j;
        int                     waited;
        pipe_pkg::load_result_t exp;
        j      = 0;
        waited = 0;
        while (j < rows.size()) begin
            @(posedge aclk);
            result_ready <= ($urandom % 3) != 0;
            @(negedge aclk);
            if (result_valid && result_ready) begin
                exp.pa    = rows[j].pa;
                exp.data  = rows[j].exc ? 32'd0 : ~rows[j].pa;
                exp.exc   = rows[j].exc;
                exp.ecode = rows[j].ecode;
                check_load(j, result, exp);
                check_exc(j, result, exp);
                j++;
                waited = 0;
            end else begin
                waited++;
                if (waited > TIMEOUT) begin
                    $display("Timeout waiting for the result of row %0d", j);
                    stop_run();
                end
            end
        end
        @(posedge aclk);
        result_ready <= 1'b1;
        // nothing may follow the last row
        repeat (20) begin
            @(negedge aclk);
            if (result_valid) begin
                $display("An extra result appeared after all rows were consumed");
                stop_run();
            end
        end
    endtask

    initial begin
        logic [31:0] mem_reads;
        void'($urandom(32'ha0c8b4f8));
        aclk         = 1'b0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        cfg          = '0;
        tlb_we       = 1'b0;
        tlb_windex   = '0;
        tlb_wentry   = '0;
        result_ready = 1'b0;
        build_tables();
        repeat (2) @(posedge aclk);
        rst <= 1'b0;
        fill_tlb();
        fork
            send_loads();
            collect_results();
        join
        // only loads without an exception reach memory
        mem_reads = '0;
        foreach (rows[i]) begin
            if (!rows[i].exc) begin
                mem_reads = mem_reads + 32'd1;
            end
        end
        check_count(req_count, mem_reads);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== mem_xlate.f ====
+incdir+.
src/xlate_pkg.sv
src/pipe_pkg.sv
src/tlb.sv
src/addr_xlate_stage.sv
src/mem_access_stage.sv
src/mem_xlate_top.sv
testbench/tb_mem_model.sv
testbench/tb_mem_xlate.sv

// ==== run.sh ====
#!/bin/sh
# build and run the load path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mem_xlate.f --top-module tb_mem_xlate \
    -o Vtb_mem_xlate && \
./obj_dir/Vtb_mem_xlate | grep -q "Verification passed" && \
echo "simulation passed" || { echo "simulation failed"; exit 1; }
